// File: rtl/adc_config.svh
`ifndef ADC_CONFIG_SVH
`define ADC_CONFIG_SVH

// converter geometry
`define ADC_NUM_CH      8
`define ADC_SAMPLE_W    12

// frame layout, sclk periods counted from 1
`define ADC_FRAME_SCLK  16
`define ADC_ADDR_FIRST  3   // ADD2..ADD0 in periods 3 to 5
`define ADC_DATA_FIRST  5   // DB11 sampled on the rising edge of period 5

`endif

// File: rtl/adc_pkg.sv
`include "adc_config.svh"

package adc_pkg;

	typedef logic [`ADC_SAMPLE_W-1:0]        adc_sample_t;
	typedef logic [$clog2(`ADC_NUM_CH)-1:0]  adc_chan_t;
	typedef logic [`ADC_NUM_CH-1:0]          chan_mask_t;
	typedef logic [7:0]                      clk_div_t;   // clk cycles per sclk half-period

	typedef struct packed {
		adc_chan_t   chan;
		adc_sample_t sample;
	} store_wr_t;

	typedef enum logic [2:0] {
		st_idle,
		st_prime,       // gap, then the first frame of a scan
		st_frame,       // gap, then the next frame
		st_wait_frame,
		st_finish
	} scan_state_t;

endpackage

// File: rtl/adc_serial_if.sv
`timescale 1ns/1ps
`include "adc_config.svh"

module adc_serial_if (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 frame_go,
	input  adc_pkg::adc_chan_t   frame_chan,
	input  adc_pkg::clk_div_t    div,
	output logic                 frame_busy,
	output logic                 frame_done,
	output adc_pkg::adc_sample_t frame_sample,
	output logic                 sclk,
	output logic                 cs_n,
	output logic                 din,
	input  logic                 dout
);

	localparam int edge_last = 2 * `ADC_FRAME_SCLK;    // extra tick closes the frame
	localparam int cnt_w = $clog2(edge_last + 1);
	localparam int addr_w = $bits(adc_pkg::adc_chan_t);

	logic                 running;
	logic                 tick;
	logic                 fall_tick;
	logic                 rise_tick;
	logic                 addr_phase;
	logic [cnt_w-1:0]     edge_cnt;  // sclk edges so far
	logic [cnt_w-2:0]     period;
	adc_pkg::clk_div_t    div_cnt;
	adc_pkg::adc_chan_t   addr_sh;
	adc_pkg::adc_sample_t shift;

	assign tick = running && (div_cnt == div - 8'd1);
	assign period = edge_cnt[cnt_w-1:1] + 1'b1;  // 1-based sclk period
	assign fall_tick = tick && !edge_cnt[0] && (edge_cnt != edge_last);
	assign rise_tick = tick && edge_cnt[0];
	assign addr_phase = (period >= `ADC_ADDR_FIRST) && (period < `ADC_ADDR_FIRST + addr_w);
	assign frame_busy = running;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			running <= 1'b0;
			div_cnt <= '0;
			edge_cnt <= '0;
			sclk <= 1'b1;
			cs_n <= 1'b1;
			din <= 1'b1;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (frame_go && !running) begin
				running <= 1'b1;
				div_cnt <= '0;
				edge_cnt <= '0;
				cs_n <= 1'b0;
			end else if (tick) begin
				div_cnt <= '0;
				edge_cnt <= edge_cnt + 1'b1;
				if (edge_cnt == edge_last) begin
					running <= 1'b0;
					cs_n <= 1'b1;
					frame_done <= 1'b1;
				end else begin
					sclk <= edge_cnt[0];  // even counts fall, odd counts rise
				end
				if (fall_tick)
					din <= addr_phase ? addr_sh[addr_w-1] : 1'b1;
			end else if (running) begin
				div_cnt <= div_cnt + 8'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (frame_go && !running)
			addr_sh <= frame_chan;
		else if (fall_tick && addr_phase)
			addr_sh <= addr_sh << 1;  // msb first
		if (rise_tick && (period >= `ADC_DATA_FIRST))
			shift <= {shift[`ADC_SAMPLE_W-2:0], dout};
		if (tick && (edge_cnt == edge_last))
			frame_sample <= shift;
	end

endmodule

// File: rtl/scan_ctrl.sv
`timescale 1ns/1ps

module scan_ctrl (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  adc_pkg::chan_mask_t  chan_mask,
	input  adc_pkg::clk_div_t    div,
	output logic                 frame_go,
	output adc_pkg::adc_chan_t   frame_chan,
	output adc_pkg::clk_div_t    frame_div,
	input  logic                 frame_busy,
	input  logic                 frame_done,
	input  adc_pkg::adc_sample_t frame_sample,
	output logic                 store_we,
	output adc_pkg::store_wr_t   store_wr,
	output logic                 busy,
	output logic                 scan_done
);

	adc_pkg::scan_state_t state;
	adc_pkg::chan_mask_t  mask_q;
	adc_pkg::chan_mask_t  above;      // enabled channels after the current one
	adc_pkg::clk_div_t    gap_cnt;
	adc_pkg::adc_chan_t   prev_chan;  // owner of the result now coming back
	logic                 discard;
	logic                 last;       // dummy frame in flight

	function automatic adc_pkg::adc_chan_t lowest_chan(input adc_pkg::chan_mask_t m);
		adc_pkg::adc_chan_t c;
		c = '0;
		for (int i = $bits(adc_pkg::chan_mask_t) - 1; i >= 0; i--)
			if (m[i])
				c = adc_pkg::adc_chan_t'(i);
		return c;
	endfunction

	assign above = mask_q & ~((adc_pkg::chan_mask_t'(2) << frame_chan) - 1'b1);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= adc_pkg::st_idle;
			mask_q <= '0;
			frame_div <= '0;
			gap_cnt <= '0;
			frame_chan <= '0;
			frame_go <= 1'b0;
			store_we <= 1'b0;
			discard <= 1'b0;
			last <= 1'b0;
			busy <= 1'b0;
			scan_done <= 1'b0;
		end else begin
			frame_go <= 1'b0;
			store_we <= 1'b0;
			scan_done <= 1'b0;
			case (state)
				adc_pkg::st_idle: if (start && |chan_mask) begin
					mask_q <= chan_mask;
					frame_div <= div;
					gap_cnt <= div;  // cs_n may have just risen
					frame_chan <= lowest_chan(chan_mask);
					discard <= 1'b1;
					last <= 1'b0;
					busy <= 1'b1;
					state <= adc_pkg::st_prime;
				end
				adc_pkg::st_prime, adc_pkg::st_frame: begin
					if (gap_cnt != '0) begin
						gap_cnt <= gap_cnt - 8'd1;
					end else if (!frame_busy) begin
						frame_go <= 1'b1;
						state <= adc_pkg::st_wait_frame;
					end
				end
				adc_pkg::st_wait_frame: if (frame_done) begin
					store_we <= !discard;  // frame 0 returns a stale conversion
					discard <= 1'b0;
					gap_cnt <= frame_div;
					if (last) begin
						state <= adc_pkg::st_finish;
					end else begin
						frame_chan <= |above ? lowest_chan(above) : lowest_chan(mask_q);
						last <= ~|above;
						state <= adc_pkg::st_frame;
					end
				end
				adc_pkg::st_finish: begin
					scan_done <= 1'b1;
					busy <= 1'b0;
					state <= adc_pkg::st_idle;
				end
				default: state <= adc_pkg::st_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == adc_pkg::st_wait_frame) && frame_done) begin
			prev_chan <= frame_chan;
			store_wr.chan <= prev_chan;
			store_wr.sample <= frame_sample;
		end
	end

endmodule

// File: rtl/sample_store.sv
`timescale 1ns/1ps
`include "adc_config.svh"

module sample_store (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 store_we,
	input  adc_pkg::store_wr_t   store_wr,
	input  adc_pkg::adc_sample_t limit,
	input  adc_pkg::adc_chan_t   rd_channel,
	output adc_pkg::adc_sample_t rd_data,
	output adc_pkg::chan_mask_t  alarm
);

	adc_pkg::adc_sample_t samples [`ADC_NUM_CH];  // latest result per channel

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `ADC_NUM_CH; i++)
				samples[i] <= '0;
		end else if (store_we) begin
			samples[store_wr.chan] <= store_wr.sample;
		end
	end

	assign rd_data = samples[rd_channel];

	// level alarm, follows limit without a new scan
	always_comb begin
		for (int i = 0; i < `ADC_NUM_CH; i++)
			alarm[i] = samples[i] > limit;
	end

endmodule

// File: rtl/adc_scan_top.sv
`timescale 1ns/1ps

module adc_scan_top (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  adc_pkg::chan_mask_t  chan_mask,
	input  adc_pkg::clk_div_t    div,
	input  adc_pkg::adc_sample_t limit,
	input  adc_pkg::adc_chan_t   rd_channel,
	input  logic                 dout,
	output logic                 sclk,
	output logic                 cs_n,
	output logic                 din,
	output logic                 busy,
	output logic                 scan_done,
	output adc_pkg::adc_sample_t rd_data,
	output adc_pkg::chan_mask_t  alarm
);

	logic                 frame_go;
	logic                 frame_busy;
	logic                 frame_done;
	logic                 store_we;
	adc_pkg::adc_chan_t   frame_chan;
	adc_pkg::clk_div_t    frame_div;
	adc_pkg::adc_sample_t frame_sample;
	adc_pkg::store_wr_t   store_wr;

	scan_ctrl u_scan_ctrl (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.chan_mask    (chan_mask),
		.div          (div),
		.frame_go     (frame_go),
		.frame_chan   (frame_chan),
		.frame_div    (frame_div),
		.frame_busy   (frame_busy),
		.frame_done   (frame_done),
		.frame_sample (frame_sample),
		.store_we     (store_we),
		.store_wr     (store_wr),
		.busy         (busy),
		.scan_done    (scan_done)
	);

	adc_serial_if u_adc_serial_if (
		.clk          (clk),
		.rst          (rst),
		.frame_go     (frame_go),
		.frame_chan   (frame_chan),
		.div          (frame_div),  // divider latched at start
		.frame_busy   (frame_busy),
		.frame_done   (frame_done),
		.frame_sample (frame_sample),
		.sclk         (sclk),
		.cs_n         (cs_n),
		.din          (din),
		.dout         (dout)
	);

	sample_store u_sample_store (
		.clk        (clk),
		.rst        (rst),
		.store_we   (store_we),
		.store_wr   (store_wr),
		.limit      (limit),
		.rd_channel (rd_channel),
		.rd_data    (rd_data),
		.alarm      (alarm)
	);

endmodule

// File: bench/adc_model.sv
`timescale 1ns/1ps
`include "adc_config.svh"

module adc_model (
	input  logic                                   sclk, cs_n, din,
	output logic                                   dout,
	input  adc_pkg::adc_sample_t [`ADC_NUM_CH-1:0] ch_value
);

	localparam int addr_w = $bits(adc_pkg::adc_chan_t);

	adc_pkg::adc_chan_t   addr_in = '0;
	adc_pkg::adc_chan_t   next_chan = '0;  // converted in the following frame
	adc_pkg::adc_sample_t held = '0;
	logic                 sclk_q = 1'b1;
	logic                 cs_n_q = 1'b1;
	logic                 dout_q = 1'b0;
	int                   fall_cnt = 0;
	int                   rise_cnt = 0;

	assign dout = dout_q;

	always @(posedge sclk or negedge sclk or posedge cs_n or negedge cs_n) begin
		if (cs_n_q && !cs_n) begin
			held = ch_value[next_chan];  // one-frame pipeline
			fall_cnt = 0;
			rise_cnt = 0;
		end else if (!cs_n_q && cs_n) begin
			next_chan = addr_in;
		end else if (!cs_n && sclk_q && !sclk) begin
			fall_cnt++;
			dout_q = (fall_cnt >= `ADC_DATA_FIRST) ? held[`ADC_FRAME_SCLK - fall_cnt] : 1'b0;
		end else if (!cs_n && !sclk_q && sclk) begin
			rise_cnt++;
			if (rise_cnt >= `ADC_ADDR_FIRST && rise_cnt < `ADC_ADDR_FIRST + addr_w)
				addr_in = adc_pkg::adc_chan_t'({addr_in, din});  // msb first
		end
		sclk_q = sclk;
		cs_n_q = cs_n;
	end

endmodule

// File: bench/scan_checker.sv
`timescale 1ns/1ps
`include "adc_config.svh"

module scan_checker (
	input  logic                                   clk, rst, start, busy, scan_done, sweep,
	input  logic                                   sclk, cs_n, din,
	input  adc_pkg::chan_mask_t                    chan_mask, alarm,
	input  adc_pkg::clk_div_t                      div,
	input  adc_pkg::adc_sample_t                   limit, rd_data,
	input  adc_pkg::adc_chan_t                     rd_channel,
	input  adc_pkg::adc_sample_t [`ADC_NUM_CH-1:0] ch_value,
	output int                                     value_errors, protocol_errors
);

	localparam int addr_w = $bits(adc_pkg::adc_chan_t);

	adc_pkg::adc_sample_t exp_store [`ADC_NUM_CH];
	adc_pkg::adc_chan_t   exp_seq [`ADC_NUM_CH + 1];  // addresses of one scan, dummy last
	adc_pkg::chan_mask_t  scan_mask, exp_alarm;
	adc_pkg::clk_div_t    scan_div;
	adc_pkg::adc_chan_t   addr_got;
	int                   n_frames, frame_idx, gap, rises;
	logic                 accept, accept_q, busy_q, sclk_q, cs_n_q;

	assign accept = start && !busy && |chan_mask;

	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			for (int i = 0; i < `ADC_NUM_CH; i++)
				exp_store[i] = '0;
			value_errors = 0;
			protocol_errors = 0;
			n_frames = 0;
			frame_idx = 0;
			gap = 0;
			rises = 0;
			accept_q = 1'b0;
			busy_q = 1'b0;
			sclk_q = 1'b1;
			cs_n_q = 1'b1;
		end else begin
			if (busy && !busy_q && !accept_q) begin
				$display("busy rose without an accepted start at %0t", $time);
				protocol_errors++;
			end
			if (accept_q && !busy) begin
				$display("an accepted start did not raise busy at %0t", $time);
				protocol_errors++;
			end
			if (accept) begin
				scan_mask = chan_mask;
				scan_div = div;
				n_frames = 0;
				frame_idx = 0;
				for (int i = 0; i < `ADC_NUM_CH; i++)
					if (chan_mask[i]) begin
						exp_seq[n_frames] = adc_pkg::adc_chan_t'(i);
						n_frames++;
					end
				exp_seq[n_frames] = exp_seq[0];  // dummy address
				n_frames++;
			end
			if (scan_done) begin
				if (frame_idx != n_frames) begin
					$display("scan ended after %0d frames, %0d expected", frame_idx, n_frames);
					protocol_errors++;
				end
				for (int i = 0; i < `ADC_NUM_CH; i++)
					if (scan_mask[i])
						exp_store[i] = ch_value[i];
			end
			if (cs_n_q && !cs_n) begin
				gap = 1;
				rises = 0;
			end else if (!cs_n_q && (sclk !== sclk_q || cs_n)) begin
				if (gap != int'(scan_div)) begin
					$display("sclk half-period of %0d cycles, %0d expected", gap, scan_div);
					protocol_errors++;
				end
				gap = 1;
				if (sclk && !sclk_q) begin
					rises++;
					if (rises >= `ADC_ADDR_FIRST && rises < `ADC_ADDR_FIRST + addr_w)
						addr_got = adc_pkg::adc_chan_t'({addr_got, din});
				end
				if (cs_n) begin
					if (rises != `ADC_FRAME_SCLK) begin
						$display("frame had %0d rising sclk edges", rises);
						protocol_errors++;
					end
					if (frame_idx >= n_frames) begin
						$display("frame outside the expected scan sequence");
						protocol_errors++;
					end else if (addr_got !== exp_seq[frame_idx]) begin
						$display("[ERROR] din address: got %h expected %h", addr_got,
							exp_seq[frame_idx]);
						value_errors++;
					end
					frame_idx++;
				end
			end else if (!cs_n_q) begin
				gap++;
			end
			if (sweep) begin
				for (int i = 0; i < `ADC_NUM_CH; i++)
					exp_alarm[i] = exp_store[i] > limit;  // strictly above
				if (rd_data !== exp_store[rd_channel]) begin
					$display("[ERROR] rd_data ch %0d: got %h expected %h", rd_channel, rd_data,
						exp_store[rd_channel]);
					value_errors++;
				end
				if (alarm !== exp_alarm) begin
					$display("[ERROR] alarm: got %h expected %h", alarm, exp_alarm);
					value_errors++;
				end
			end
			accept_q = accept;
			busy_q = busy;
			sclk_q = sclk;
			cs_n_q = cs_n;
		end
	end

endmodule

// File: bench/adc_scan_asserts.sv
`timescale 1ns/1ps

module adc_scan_asserts (
	input logic clk, rst, sclk, cs_n, din, busy, scan_done
);

	sclk_idle_high: assert property (@(posedge clk) disable iff (!rst) cs_n |-> sclk)
		else $error("sclk low while cs_n is high");

	done_one_cycle: assert property (@(posedge clk) disable iff (!rst) scan_done |=> !scan_done)
		else $error("scan_done longer than one cycle");

	busy_low_after_done: assert property (@(posedge clk) disable iff (!rst) scan_done |=> !busy)
		else $error("busy still high after scan_done");

	din_stable_high: assert property (@(posedge clk) disable iff (!rst)
		sclk && $past(sclk) |-> $stable(din))
		else $error("din changed while sclk was high");

endmodule

bind adc_scan_top adc_scan_asserts u_adc_scan_asserts (
	.clk       (clk),
	.rst       (rst),
	.sclk      (sclk),
	.cs_n      (cs_n),
	.din       (din),
	.busy      (busy),
	.scan_done (scan_done)
);

// File: bench/tb_adc_scan.sv
`timescale 1ns/1ps
`include "adc_config.svh"

module tb_adc_scan;

	localparam int num_passes = 8;
	localparam int words_per_pass = 4 + `ADC_NUM_CH;
	localparam int scan_timeout = 200000;
	localparam int busy_timeout = 1000;
	localparam int idle_window = 200;  // cycles watched after an ignored start

	logic                                   clk, rst, start, dout, sweep, timed_out;
	logic                                   sclk, cs_n, din, busy, scan_done;
	adc_pkg::chan_mask_t                    chan_mask, alarm;
	adc_pkg::clk_div_t                      div;
	adc_pkg::adc_sample_t                   limit, rd_data;
	adc_pkg::adc_chan_t                     rd_channel;
	adc_pkg::adc_sample_t [`ADC_NUM_CH-1:0] ch_value;
	logic [11:0]                            vec [num_passes * words_per_pass];
	int                                     value_errors, protocol_errors;

	always #20 clk = ~clk;

	adc_scan_top u_adc_scan_top (
		.clk (clk), .rst (rst), .start (start), .chan_mask (chan_mask), .div (div),
		.limit (limit), .rd_channel (rd_channel), .dout (dout), .sclk (sclk), .cs_n (cs_n),
		.din (din), .busy (busy), .scan_done (scan_done), .rd_data (rd_data), .alarm (alarm)
	);

	adc_model u_adc_model (
		.sclk (sclk), .cs_n (cs_n), .din (din), .dout (dout), .ch_value (ch_value)
	);

	scan_checker u_scan_checker (
		.clk (clk), .rst (rst), .start (start), .busy (busy), .scan_done (scan_done),
		.sweep (sweep), .sclk (sclk), .cs_n (cs_n), .din (din), .chan_mask (chan_mask),
		.alarm (alarm), .div (div), .limit (limit), .rd_data (rd_data),
		.rd_channel (rd_channel), .ch_value (ch_value), .value_errors (value_errors),
		.protocol_errors (protocol_errors)
	);

	task automatic pulse_start();
		@(negedge clk) start = 1'b1;
		@(negedge clk) start = 1'b0;
	endtask

	task automatic wait_level(ref logic sig, input int limit_cycles, input string what);
		int n;
		n = 0;
		while (sig !== 1'b1 && n < limit_cycles) begin
			@(negedge clk);
			n++;
		end
		if (sig !== 1'b1) begin
			$display("timeout: %s not seen within %0d cycles", what, limit_cycles);
			timed_out = 1'b1;
		end
	endtask

	task automatic sweep_store();
		for (int c = 0; c < `ADC_NUM_CH; c++) begin
			@(negedge clk);
			rd_channel = adc_pkg::adc_chan_t'(c);
			sweep = 1'b1;
		end
		@(negedge clk) sweep = 1'b0;
	endtask

	task automatic run_pass(input int p);
		int base;
		base = p * words_per_pass;
		@(negedge clk);
		chan_mask = vec[base + 1][7:0];
		div = vec[base + 2][7:0];
		limit = vec[base + 3];
		for (int i = 0; i < `ADC_NUM_CH; i++)
			ch_value[i] = vec[base + 4 + i];
		pulse_start();
		if (vec[base] == 12'h0) begin
			repeat (idle_window) @(negedge clk);  // checker flags any busy here
		end else begin
			if (vec[base] == 12'h2) begin
				wait_level(busy, busy_timeout, "busy");
				chan_mask = ~chan_mask;  // a start while busy must be ignored
				pulse_start();
			end
			if (!timed_out)
				wait_level(scan_done, scan_timeout, "scan_done");
		end
		if (!timed_out)
			sweep_store();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		start = 1'b0;
		sweep = 1'b0;
		timed_out = 1'b0;
		chan_mask = '0;
		div = 8'd2;
		limit = '0;
		rd_channel = '0;
		ch_value = '0;
		$readmemh("bench/adc_scan_input.txt", vec);
		repeat (10) @(posedge clk);
		@(negedge clk) rst = 1'b1;
		for (int p = 0; p < num_passes && !timed_out; p++)
			run_pass(p);
		@(negedge clk);
		$display("value errors %0d, protocol errors %0d, timeouts %0d",
			value_errors, protocol_errors, timed_out);
		if (value_errors == 0 && protocol_errors == 0 && !timed_out)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// File: bench/adc_scan_input.txt
// flag mask div limit ch0 ch1 ch2 ch3 ch4 ch5 ch6 ch7, all hex
// flag 0 start ignored, 1 scan, 2 scan with a second start while busy
1 ff 02 800 0a1 1b2 2c3 3d4 8e5 9f6 a07 b18
1 55 03 400 111 222 333 444 555 666 777 888
0 00 02 100 fff fff fff fff fff fff fff fff
2 0a 04 7ff 7fe 800 7ff 801 000 fff 123 456
1 80 02 000 000 000 000 000 000 000 000 c3c
1 01 05 fff fff 000 000 000 000 000 000 000
1 c3 10 3c3 3c4 3c2 abc def 135 246 3c3 3c3
0 00 02 555 000 000 000 000 000 000 000 000

// File: files.f
+incdir+rtl
rtl/adc_pkg.sv
rtl/adc_serial_if.sv
rtl/scan_ctrl.sv
rtl/sample_store.sv
rtl/adc_scan_top.sv
bench/adc_model.sv
bench/scan_checker.sv
bench/adc_scan_asserts.sv
bench/tb_adc_scan.sv

// File: Makefile
TOP = tb_adc_scan

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wall -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log
